//--- mem_pkg.sv
package mem_pkg;

  // request opcode, one bit on the wire
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // number of banks, power of two only
  localparam int DEF_NUM_BANKS = 4;

  // total word address, 1k words
  localparam int DEF_ADDR_W = 10;

  localparam int DEF_DATA_W = 32;

  // bank queue depth, also merger buffer depth per bank
  localparam int DEF_BANK_Q_DEPTH = 4;

  // host fifo depth and host credits after reset
  localparam int DEF_HOST_CREDITS = 4;

endpackage

//--- sram_sync.sv
`timescale 1ns/1ps

module sram_sync #(
  parameter int AW = 10,
  parameter int DW = 32
)(
  input  logic          CLK,
  input  logic [AW-1:0] a,
  input  logic [DW-1:0] di,
  input  logic          ce_n,
  input  logic          we_n,
  output logic [DW-1:0] dout
);

  localparam int WORDS = 1 << AW;

  logic [DW-1:0] ram [WORDS];

  // part powers up with all words zero
  initial
  begin
    for (int i = 0; i < WORDS; i++)
    begin
      ram[i] = '0;
    end
  end

  always @(posedge CLK)
  begin
    if (!ce_n && !we_n)
    begin
      ram[a] <= di;
    end
  end

  // registered read port, old data on a same-cycle write
  always_ff @(posedge CLK)
  begin
    if (!ce_n)
    begin
      dout <= ram[a];
    end
  end

endmodule

//--- req_dispatch.sv
`timescale 1ns/1ps

module req_dispatch
  import mem_pkg::*;
#(
  parameter int NUM_BANKS    = DEF_NUM_BANKS,
  parameter int ADDR_W       = DEF_ADDR_W,
  parameter int DATA_W       = DEF_DATA_W,
  parameter int BANK_Q_DEPTH = DEF_BANK_Q_DEPTH,
  parameter int HOST_CREDITS = DEF_HOST_CREDITS,
  localparam int BW          = $clog2(NUM_BANKS),
  localparam int BA_W        = ADDR_W - BW
)(
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 req_valid,
  input  mem_op_e              req_op,
  input  logic [ADDR_W-1:0]    req_addr,
  input  logic [DATA_W-1:0]    req_wdata,
  output logic                 req_credit,
  output logic [NUM_BANKS-1:0] bank_req_valid,
  output mem_op_e              bank_req_op,
  output logic [BA_W-1:0]      bank_req_addr,
  output logic [DATA_W-1:0]    bank_req_wdata,
  input  logic [NUM_BANKS-1:0] bank_credit,
  output logic                 ord_push,
  output logic [BW-1:0]        ord_bank
);

  localparam int PW  = (HOST_CREDITS > 1) ? $clog2(HOST_CREDITS) : 1;
  localparam int FCW = $clog2(HOST_CREDITS + 1);
  localparam int CW  = $clog2(BANK_Q_DEPTH + 1);

  mem_op_e           fifo_op    [HOST_CREDITS];
  logic [ADDR_W-1:0] fifo_addr  [HOST_CREDITS];
  logic [DATA_W-1:0] fifo_wdata [HOST_CREDITS];
  logic [PW-1:0]     wr_ptr;
  logic [PW-1:0]     rd_ptr;
  logic [FCW-1:0]    fifo_cnt;
  logic [CW-1:0]     bank_cnt   [NUM_BANKS];

  mem_op_e           head_op;
  logic [ADDR_W-1:0] head_addr;
  logic [BW-1:0]     head_bank;
  logic              fwd;

  assign head_op   = fifo_op[rd_ptr];
  assign head_addr = fifo_addr[rd_ptr];
  // low address bits pick the bank
  assign head_bank = head_addr[BW-1:0];
  // head blocks until its bank has room
  assign fwd       = (fifo_cnt != '0) && (bank_cnt[head_bank] != '0);

  // host fifo storage, the host never sends without a credit
  always_ff @(posedge CLK)
  begin
    if (req_valid)
    begin
      fifo_op[wr_ptr]    <= req_op;
      fifo_addr[wr_ptr]  <= req_addr;
      fifo_wdata[wr_ptr] <= req_wdata;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end
    else
    begin
      if (req_valid)
      begin
        wr_ptr <= (wr_ptr == PW'(HOST_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (fwd)
      begin
        rd_ptr <= (rd_ptr == PW'(HOST_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (req_valid && !fwd)
      begin
        fifo_cnt <= fifo_cnt + 1'b1;
      end
      else if (!req_valid && fwd)
      begin
        fifo_cnt <= fifo_cnt - 1'b1;
      end
    end
  end

  // free slots in each bank queue
  always_ff @(posedge CLK)
  begin
    for (int i = 0; i < NUM_BANKS; i++)
    begin
      if (!rst_n)
      begin
        bank_cnt[i] <= CW'(BANK_Q_DEPTH);
      end
      else
      begin
        bank_cnt[i] <= bank_cnt[i] + CW'(bank_credit[i])
                       - CW'(fwd && (head_bank == BW'(i)));
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      bank_req_valid <= '0;
      req_credit     <= 1'b0;
      ord_push       <= 1'b0;
    end
    else
    begin
      bank_req_valid <= fwd ? (NUM_BANKS'(1) << head_bank) : '0;
      // slot freed in the host fifo
      req_credit     <= fwd;
      ord_push       <= fwd && (head_op == OP_READ);
    end
  end

  always_ff @(posedge CLK)
  begin
    if (fwd)
    begin
      bank_req_op    <= head_op;
      bank_req_addr  <= head_addr[ADDR_W-1:BW];
      bank_req_wdata <= fifo_wdata[rd_ptr];
      ord_bank       <= head_bank;
    end
  end

endmodule

//--- bank_ctrl.sv
`timescale 1ns/1ps

module bank_ctrl
  import mem_pkg::*;
#(
  parameter int NUM_BANKS    = DEF_NUM_BANKS,
  parameter int ADDR_W       = DEF_ADDR_W,
  parameter int DATA_W       = DEF_DATA_W,
  parameter int BANK_Q_DEPTH = DEF_BANK_Q_DEPTH,
  localparam int BA_W        = ADDR_W - $clog2(NUM_BANKS)
)(
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              req_valid,
  input  mem_op_e           req_op,
  input  logic [BA_W-1:0]   req_addr,
  input  logic [DATA_W-1:0] req_wdata,
  output logic              credit,
  output logic              rd_valid,
  output logic [DATA_W-1:0] rd_data,
  input  logic              rd_credit
);

  localparam int PW = (BANK_Q_DEPTH > 1) ? $clog2(BANK_Q_DEPTH) : 1;
  localparam int CW = $clog2(BANK_Q_DEPTH + 1);

  mem_op_e           q_op    [BANK_Q_DEPTH];
  logic [BA_W-1:0]   q_addr  [BANK_Q_DEPTH];
  logic [DATA_W-1:0] q_wdata [BANK_Q_DEPTH];
  logic [PW-1:0]     wr_ptr;
  logic [PW-1:0]     rd_ptr;
  logic [CW-1:0]     q_cnt;
  logic [CW-1:0]     mrg_cnt;

  logic              is_write;
  logic              issue;
  logic              rd_issue;
  logic              sram_ce_n;
  logic              sram_we_n;

  assign is_write = (q_op[rd_ptr] == OP_WRITE);
  // reads need a free merger slot, writes go straight through
  assign issue    = (q_cnt != '0) && (is_write || (mrg_cnt != '0));
  assign rd_issue = issue && !is_write;

  assign sram_ce_n = ~issue;
  assign sram_we_n = ~is_write;

  always_ff @(posedge CLK)
  begin
    if (req_valid)
    begin
      q_op[wr_ptr]    <= req_op;
      q_addr[wr_ptr]  <= req_addr;
      q_wdata[wr_ptr] <= req_wdata;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_cnt   <= '0;
      mrg_cnt <= CW'(BANK_Q_DEPTH);
      credit  <= 1'b0;
    end
    else
    begin
      if (req_valid)
      begin
        wr_ptr <= (wr_ptr == PW'(BANK_Q_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (issue)
      begin
        rd_ptr <= (rd_ptr == PW'(BANK_Q_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      q_cnt   <= q_cnt + CW'(req_valid) - CW'(issue);
      mrg_cnt <= mrg_cnt + CW'(rd_credit) - CW'(rd_issue);
      // every pop frees a slot the dispatcher can reuse
      credit  <= issue;
    end
  end

  // valid lines up with the registered sram output
  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= rd_issue;
    end
  end

  sram_sync #(
    .AW (BA_W),
    .DW (DATA_W)
  ) u_sram (
    .CLK  (CLK),
    .a    (q_addr[rd_ptr]),
    .di   (q_wdata[rd_ptr]),
    .ce_n (sram_ce_n),
    .we_n (sram_we_n),
    .dout (rd_data)
  );

endmodule

//--- rsp_merge.sv
`timescale 1ns/1ps

module rsp_merge
  import mem_pkg::*;
#(
  parameter int NUM_BANKS    = DEF_NUM_BANKS,
  parameter int DATA_W       = DEF_DATA_W,
  parameter int BANK_Q_DEPTH = DEF_BANK_Q_DEPTH,
  localparam int BW          = $clog2(NUM_BANKS)
)(
  input  logic                              CLK,
  input  logic                              rst_n,
  input  logic                              ord_push,
  input  logic [BW-1:0]                     ord_bank,
  input  logic [NUM_BANKS-1:0]              rd_valid,
  input  logic [NUM_BANKS-1:0][DATA_W-1:0]  rd_data,
  output logic [NUM_BANKS-1:0]              rd_credit,
  output logic                              rsp_valid,
  output logic [DATA_W-1:0]                 rsp_data
);

  localparam int PW  = (BANK_Q_DEPTH > 1) ? $clog2(BANK_Q_DEPTH) : 1;
  localparam int CW  = $clog2(BANK_Q_DEPTH + 1);
  // a bank can hold a full queue plus a full buffer of reads
  localparam int ORD_DEPTH = 2 * NUM_BANKS * BANK_Q_DEPTH;
  localparam int OPW = $clog2(ORD_DEPTH);
  localparam int OCW = $clog2(ORD_DEPTH + 1);

  logic [BW-1:0]     ord_mem [ORD_DEPTH];
  logic [OPW-1:0]    ord_wr_ptr;
  logic [OPW-1:0]    ord_rd_ptr;
  logic [OCW-1:0]    ord_cnt;

  logic [DATA_W-1:0]    buf_head [NUM_BANKS];
  logic [NUM_BANKS-1:0] buf_nempty;
  logic [BW-1:0]        head_bank;
  logic                 pop;

  assign head_bank = ord_mem[ord_rd_ptr];
  // oldest outstanding read decides which bank drains next
  assign pop       = (ord_cnt != '0) && buf_nempty[head_bank];

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_buf
    logic [DATA_W-1:0] mem [BANK_Q_DEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW-1:0]     rd_ptr;
    logic [CW-1:0]     cnt;
    logic              pop_b;

    assign pop_b         = pop && (head_bank == BW'(b));
    assign buf_head[b]   = mem[rd_ptr];
    assign buf_nempty[b] = (cnt != '0);

    always_ff @(posedge CLK)
    begin
      if (rd_valid[b])
      begin
        mem[wr_ptr] <= rd_data[b];
      end
    end

    always_ff @(posedge CLK)
    begin
      if (!rst_n)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        cnt    <= '0;
      end
      else
      begin
        if (rd_valid[b])
        begin
          wr_ptr <= (wr_ptr == PW'(BANK_Q_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop_b)
        begin
          rd_ptr <= (rd_ptr == PW'(BANK_Q_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        cnt <= cnt + CW'(rd_valid[b]) - CW'(pop_b);
      end
    end
  end

  // order fifo of bank numbers
  always_ff @(posedge CLK)
  begin
    if (ord_push)
    begin
      ord_mem[ord_wr_ptr] <= ord_bank;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      ord_wr_ptr <= '0;
      ord_rd_ptr <= '0;
      ord_cnt    <= '0;
      rsp_valid  <= 1'b0;
      rd_credit  <= '0;
    end
    else
    begin
      if (ord_push)
      begin
        ord_wr_ptr <= (ord_wr_ptr == OPW'(ORD_DEPTH - 1)) ? '0 : ord_wr_ptr + 1'b1;
      end
      if (pop)
      begin
        ord_rd_ptr <= (ord_rd_ptr == OPW'(ORD_DEPTH - 1)) ? '0 : ord_rd_ptr + 1'b1;
      end
      ord_cnt   <= ord_cnt + OCW'(ord_push) - OCW'(pop);
      rsp_valid <= pop;
      rd_credit <= pop ? (NUM_BANKS'(1) << head_bank) : '0;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (pop)
    begin
      rsp_data <= buf_head[head_bank];
    end
  end

endmodule

//--- banked_ram_top.sv
`timescale 1ns/1ps

module banked_ram_top
  import mem_pkg::*;
#(
  parameter int NUM_BANKS    = DEF_NUM_BANKS,
  parameter int ADDR_W       = DEF_ADDR_W,
  parameter int DATA_W       = DEF_DATA_W,
  parameter int BANK_Q_DEPTH = DEF_BANK_Q_DEPTH,
  parameter int HOST_CREDITS = DEF_HOST_CREDITS
)(
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              req_valid,
  input  mem_op_e           req_op,
  input  logic [ADDR_W-1:0] req_addr,
  input  logic [DATA_W-1:0] req_wdata,
  output logic              req_credit,
  output logic              rsp_valid,
  output logic [DATA_W-1:0] rsp_data
);

  localparam int BW   = $clog2(NUM_BANKS);
  localparam int BA_W = ADDR_W - BW;

  // dispatcher to banks, payload shared by all banks
  logic [NUM_BANKS-1:0]             bank_req_valid;
  mem_op_e                          bank_req_op;
  logic [BA_W-1:0]                  bank_req_addr;
  logic [DATA_W-1:0]                bank_req_wdata;
  logic [NUM_BANKS-1:0]             bank_credit;

  logic                             ord_push;
  logic [BW-1:0]                    ord_bank;

  // banks to merger
  logic [NUM_BANKS-1:0]             rd_valid;
  logic [NUM_BANKS-1:0][DATA_W-1:0] rd_data;
  logic [NUM_BANKS-1:0]             rd_credit;

  req_dispatch #(
    .NUM_BANKS    (NUM_BANKS),
    .ADDR_W       (ADDR_W),
    .DATA_W       (DATA_W),
    .BANK_Q_DEPTH (BANK_Q_DEPTH),
    .HOST_CREDITS (HOST_CREDITS)
  ) u_dispatch (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_op         (req_op),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .req_credit     (req_credit),
    .bank_req_valid (bank_req_valid),
    .bank_req_op    (bank_req_op),
    .bank_req_addr  (bank_req_addr),
    .bank_req_wdata (bank_req_wdata),
    .bank_credit    (bank_credit),
    .ord_push       (ord_push),
    .ord_bank       (ord_bank)
  );

  for (genvar i = 0; i < NUM_BANKS; i++)
  begin : g_bank
    bank_ctrl #(
      .NUM_BANKS    (NUM_BANKS),
      .ADDR_W       (ADDR_W),
      .DATA_W       (DATA_W),
      .BANK_Q_DEPTH (BANK_Q_DEPTH)
    ) u_bank (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .req_valid (bank_req_valid[i]),
      .req_op    (bank_req_op),
      .req_addr  (bank_req_addr),
      .req_wdata (bank_req_wdata),
      .credit    (bank_credit[i]),
      .rd_valid  (rd_valid[i]),
      .rd_data   (rd_data[i]),
      .rd_credit (rd_credit[i])
    );
  end

  rsp_merge #(
    .NUM_BANKS    (NUM_BANKS),
    .DATA_W       (DATA_W),
    .BANK_Q_DEPTH (BANK_Q_DEPTH)
  ) u_merge (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .ord_push  (ord_push),
    .ord_bank  (ord_bank),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .rd_credit (rd_credit),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data)
  );

endmodule

//--- tb_banked_ram.sv
`timescale 1ns/1ps

module tb_banked_ram
  import mem_pkg::*;
();

  localparam int NUM_BANKS    = DEF_NUM_BANKS;
  localparam int ADDR_W       = DEF_ADDR_W;
  localparam int DATA_W       = DEF_DATA_W;
  localparam int HOST_CREDITS = DEF_HOST_CREDITS;
  localparam int WORDS        = 1 << ADDR_W;

  localparam int N_ZERO  = 8;
  localparam int N_PAIRS = 8;
  localparam int N_RAND  = 1500;
  localparam int N_BURST = 48;
  localparam int TOTAL_REQS = N_ZERO + 2 * N_PAIRS + N_RAND + N_BURST;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_REQS + 1000;
  localparam int DRAIN_CYCLES = 200;

  logic              CLK;
  logic              rst_n;
  logic              req_valid;
  mem_op_e           req_op;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  logic              req_credit;
  logic              rsp_valid;
  logic [DATA_W-1:0] rsp_data;

  // reference memory and expected read results in request order
  logic [DATA_W-1:0] model [WORDS];
  logic [DATA_W-1:0] exp_q [$];
  string             name_q [$];

  int unsigned lcg_state = 77;
  int          credits;
  int          credit_pulses;
  int          sent;
  int          reads_sent;
  int          rsp_count;

  banked_ram_top dut_i (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data)
  );

  always #20 CLK = ~CLK;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_data(string name, logic [DATA_W-1:0] exp_val,
                            logic [DATA_W-1:0] act_val);
    if (act_val !== exp_val)
    begin
      fail_run($sformatf("FAIL %s expected %h actual %h", name, exp_val, act_val));
    end
  endtask

  task automatic check_bit(string name, logic exp_val, logic act_val);
    if (act_val !== exp_val)
    begin
      fail_run($sformatf("FAIL %s expected %b actual %b", name, exp_val, act_val));
    end
  endtask

  task automatic check_count(string name, int exp_val, int act_val);
    if (act_val != exp_val)
    begin
      fail_run($sformatf("FAIL %s expected %0d actual %0d", name, exp_val, act_val));
    end
  endtask

  task automatic handle_rsp();
    logic [DATA_W-1:0] exp_val;
    string             name;
    if (exp_q.size() == 0)
    begin
      fail_run("a response arrived while no read was outstanding");
    end
    exp_val = exp_q.pop_front();
    name    = name_q.pop_front();
    rsp_count++;
    check_data(name, exp_val, rsp_data);
  endtask

  // advance to the next falling edge and sample outputs
  task automatic step_cycle();
    @(negedge CLK);
    req_valid = 1'b0;
    if (req_credit === 1'b1)
    begin
      credits++;
      credit_pulses++;
      if (credits > HOST_CREDITS)
      begin
        fail_run("host got back more credits than the request FIFO holds");
      end
    end
    if (rsp_valid === 1'b1)
    begin
      handle_rsp();
    end
  endtask

  task automatic send_req(string name, mem_op_e op, logic [ADDR_W-1:0] addr,
                          logic [DATA_W-1:0] data);
    step_cycle();
    while (credits == 0)
    begin
      step_cycle();
    end
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = data;
    credits--;
    sent++;
    if (op == OP_WRITE)
    begin
      model[addr] = data;
    end
    else
    begin
      exp_q.push_back(model[addr]);
      name_q.push_back(name);
      reads_sent++;
    end
  endtask

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge CLK);
    fail_run("watchdog expired before the traffic drained, the DUT looks hung");
  end

  initial
  begin
    int unsigned       r_ctl;
    int unsigned       r_addr;
    int unsigned       r_hi;
    int unsigned       r_lo;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    int                waited;

    CLK       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_op    = OP_READ;
    req_addr  = '0;
    req_wdata = '0;
    credits       = 0;
    credit_pulses = 0;
    sent          = 0;
    reads_sent    = 0;
    rsp_count     = 0;
    for (int i = 0; i < WORDS; i++)
    begin
      model[i] = '0;
    end

    repeat (3) @(posedge CLK);
    @(negedge CLK);
    rst_n   = 1'b1;
    credits = HOST_CREDITS;

    // quiet outputs after reset
    repeat (5)
    begin
      @(negedge CLK);
      check_bit("idle req_credit", 1'b0, req_credit);
      check_bit("idle rsp_valid", 1'b0, rsp_valid);
    end

    for (int i = 0; i < N_ZERO; i++)
    begin
      send_req("unwritten read", OP_READ, ADDR_W'(i * 37 + 5), '0);
    end

    for (int i = 0; i < N_PAIRS; i++)
    begin
      r_addr = lcg_next();
      r_hi   = lcg_next();
      r_lo   = lcg_next();
      addr   = ADDR_W'(r_addr >> 16);
      data   = {r_hi[31:16], r_lo[31:16]};
      send_req("write then read", OP_WRITE, addr, data);
      send_req("write then read", OP_READ, addr, '0);
    end

    // random mix over all banks with idle gaps
    for (int i = 0; i < N_RAND; i++)
    begin
      r_ctl = lcg_next();
      while (r_ctl[30:29] == 2'b00)
      begin
        step_cycle();
        r_ctl = lcg_next();
      end
      r_addr = lcg_next();
      r_hi   = lcg_next();
      r_lo   = lcg_next();
      addr   = ADDR_W'(r_addr >> 16);
      data   = {r_hi[31:16], r_lo[31:16]};
      send_req("random mix", mem_op_e'(r_ctl[31]), addr, data);
    end

    // every request lands in bank 2
    for (int i = 0; i < N_BURST; i++)
    begin
      r_ctl  = lcg_next();
      r_addr = lcg_next();
      r_lo   = lcg_next();
      addr   = {r_addr[23:16], 2'b10};
      send_req("single bank burst", mem_op_e'(r_ctl[31]), addr, r_lo);
    end

    // drain outstanding responses and credits
    waited = 0;
    while ((exp_q.size() != 0 || credit_pulses != sent) && waited < DRAIN_CYCLES)
    begin
      step_cycle();
      waited++;
    end
    repeat (20) step_cycle();

    check_count("credit pulses", sent, credit_pulses);
    check_count("responses", reads_sent, rsp_count);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- sources.f
mem_pkg.sv
sram_sync.sv
req_dispatch.sv
bank_ctrl.sv
rsp_merge.sv
banked_ram_top.sv
tb_banked_ram.sv

//--- run_sim.sh
#!/bin/sh
# build and run the banked RAM testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal \
  --top-module tb_banked_ram \
  -f sources.f \
  -o sim_banked_ram

./obj_dir/sim_banked_ram 2>&1 | tee sim.log

if grep -q -F '*** TEST PASSED ***' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
